// ==== design/hci_mem_pkg.sv ====
/*
 * hci memory word package.
 * sizes and types of the memory side of the interconnect:
 * data word, byte address and byte enables.
 */

package hci_mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // word geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned MEM_DW = 32;          // data word width.
  localparam int unsigned MEM_AW = 32;          // byte address width.
  localparam int unsigned MEM_BW = MEM_DW / 8;  // bytes per word.

  // one data word.
  typedef logic [MEM_DW-1:0] mem_data_t;

  // byte address as issued by an initiator.
  typedef logic [MEM_AW-1:0] mem_addr_t;

  // one enable per byte lane, bit i guards data[8*i +: 8].
  typedef logic [MEM_BW-1:0] mem_be_t;

endpackage : hci_mem_pkg

// ==== design/hci_chan_pkg.sv ====
/*
 * hci channel package.
 * channel id carried with each request and echoed with its
 * response, plus the response opcode.
 */

package hci_chan_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // channel side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned MAX_CHAN = 4;                  // upper bound on NB_CHAN.
  localparam int unsigned CHAN_IW  = $clog2(MAX_CHAN);   // id width.

  // channel index, travels with the request and comes back with r_id.
  typedef logic [CHAN_IW-1:0] chan_id_t;

  // response kind on r_opc.
  typedef enum logic {
    RESP_RD    = 1'b0,  // read response, r_data valid.
    RESP_WR_ACK = 1'b1  // write acknowledge, r_data is zero.
  } resp_opc_t;

endpackage : hci_chan_pkg

// ==== design/hci_core_mux_static.sv ====
/*
 * static hci multiplexer.
 * forwards the request of the channel picked by sel_i to one memory
 * port, stamped with the channel index as id. responses are steered
 * back by r_id, so they reach their owner after sel_i has moved.
 */

`timescale 1ns/1ns

module hci_core_mux_static
  import hci_mem_pkg::*;
  import hci_chan_pkg::*;
#(
  parameter int unsigned NB_CHAN = 2
) (
  input  logic                     clk_i,      // bind hook only.
  input  logic                     reset_i,    // bind hook only.
  input  chan_id_t                 sel_i,

  // channel side.
  input  logic      [NB_CHAN-1:0]  in_req_i,
  input  mem_addr_t [NB_CHAN-1:0]  in_add_i,
  input  logic      [NB_CHAN-1:0]  in_wen_i,
  input  mem_data_t [NB_CHAN-1:0]  in_data_i,
  input  mem_be_t   [NB_CHAN-1:0]  in_be_i,
  input  logic      [NB_CHAN-1:0]  in_r_ready_i,
  output logic      [NB_CHAN-1:0]  in_gnt_o,
  output logic      [NB_CHAN-1:0]  in_r_valid_o,
  output mem_data_t [NB_CHAN-1:0]  in_r_data_o,
  output resp_opc_t [NB_CHAN-1:0]  in_r_opc_o,

  // memory side.
  output logic                     out_req_o,
  output mem_addr_t                out_add_o,
  output logic                     out_wen_o,
  output mem_data_t                out_data_o,
  output mem_be_t                  out_be_o,
  output chan_id_t                 out_id_o,
  output logic                     out_r_ready_o,
  input  logic                     out_gnt_i,
  input  logic                     out_r_valid_i,
  input  mem_data_t                out_r_data_i,
  input  resp_opc_t                out_r_opc_i,
  input  chan_id_t                 out_r_id_i
);

  // channel count must fit the id field.
  if (NB_CHAN > MAX_CHAN || NB_CHAN == 0) begin : g_bad_nb_chan
    $error("hci_core_mux_static: NB_CHAN out of range 1..MAX_CHAN");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // a sel_i beyond NB_CHAN-1 selects nothing, so no req goes out.
  always_comb begin : req_select
    out_req_o  = 1'b0;
    out_add_o  = '0;
    out_wen_o  = 1'b1;   // idle looks like a read.
    out_data_o = '0;
    out_be_o   = '0;
    out_id_o   = '0;
    for (int i = 0; i < NB_CHAN; i++) begin
      if (sel_i == chan_id_t'(i)) begin
        out_req_o  = in_req_i[i];
        out_add_o  = in_add_i[i];
        out_wen_o  = in_wen_i[i];
        out_data_o = in_data_i[i];
        out_be_o   = in_be_i[i];
        out_id_o   = chan_id_t'(i);  // id is the channel index.
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ready comes from whoever owns the head response.
  always_comb begin : rdy_select
    out_r_ready_o = 1'b0;
    for (int i = 0; i < NB_CHAN; i++) begin
      if (out_r_id_i == chan_id_t'(i)) begin
        out_r_ready_o = in_r_ready_i[i];
      end
    end
  end

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : g_chan
    assign in_gnt_o[ii]     = (sel_i == chan_id_t'(ii)) ? out_gnt_i : 1'b0;       // selected only.
    assign in_r_valid_o[ii] = (out_r_id_i == chan_id_t'(ii)) ? out_r_valid_i : 1'b0;
    assign in_r_data_o[ii]  = out_r_data_i;  // broadcast.
    assign in_r_opc_o[ii]   = out_r_opc_i;   // broadcast.
  end

endmodule : hci_core_mux_static

// ==== design/hci_mem_bank.sv ====
/*
 * hci memory bank.
 * single-port word memory with byte-enable writes. every granted
 * request queues one response in a two-entry in-order queue, and
 * grant drops when that queue has no room after this cycle's pop.
 */

`timescale 1ns/1ns

module hci_mem_bank
  import hci_mem_pkg::*;
  import hci_chan_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic       clk_i,
  input  logic       reset_i,

  // request side.
  input  logic       req_i,
  input  mem_addr_t  add_i,
  input  logic       wen_i,     // high = read, low = write.
  input  mem_data_t  data_i,
  input  mem_be_t    be_i,
  input  chan_id_t   id_i,
  output logic       gnt_o,

  // response side.
  output logic       r_valid_o,
  output mem_data_t  r_data_o,
  output resp_opc_t  r_opc_o,
  output chan_id_t   r_id_o,
  input  logic       r_ready_i
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // local sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned IDX_W   = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int unsigned BOFF_W  = $clog2(MEM_BW);  // byte offset bits.
  localparam int unsigned Q_DEPTH = 2;               // response slots.

  // storage.
  mem_data_t          mem_q [MEM_WORDS];

  // response queue, payload and control.
  mem_data_t          q_data_q [Q_DEPTH];
  resp_opc_t          q_opc_q  [Q_DEPTH];
  chan_id_t           q_id_q   [Q_DEPTH];
  logic               wr_ptr_q;           // depth 2, one bit wraps.
  logic               rd_ptr_q;
  logic [1:0]         count_q;            // 0..2 entries.

  logic [IDX_W-1:0]   word_idx;
  logic               push;
  logic               pop;
  mem_data_t          resp_data;
  resp_opc_t          resp_opc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // addressing and handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // drop the byte offset, wrap the word part into the bank.
  assign word_idx = IDX_W'((add_i >> BOFF_W) % MEM_WORDS);

  assign pop   = r_valid_o & r_ready_i;                        // head taken.
  assign gnt_o = (count_q < Q_DEPTH) | pop;                    // room after pop.
  assign push  = req_i & gnt_o;                                // request accepted.

  // what goes into the queue for this request.
  always_comb begin : resp_build
    if (wen_i) begin
      resp_data = mem_q[word_idx];  // old word, before any update.
      resp_opc  = RESP_RD;
    end else begin
      resp_data = '0;               // write ack carries no data.
      resp_opc  = RESP_WR_ACK;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory array
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // contents start at zero after reset, writes merge under be.
  always_ff @(posedge clk_i) begin : mem_write
    if (reset_i) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (push && !wen_i) begin
      for (int b = 0; b < MEM_BW; b++) begin
        if (be_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= data_i[8*b +: 8];  // enabled lane only.
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response queue
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // payload slots, written at the tail.
  always_ff @(posedge clk_i) begin : q_payload
    if (push) begin
      q_data_q[wr_ptr_q] <= resp_data;
      q_opc_q[wr_ptr_q]  <= resp_opc;
      q_id_q[wr_ptr_q]   <= id_i;      // owner, echoed on r_id.
    end
  end

  // pointers and fill level.
  always_ff @(posedge clk_i) begin : q_ctrl
    if (reset_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;  // fill.
        2'b01:   count_q <= count_q - 2'd1;  // drain.
        default: count_q <= count_q;         // idle or both, level holds.
      endcase
    end
  end

  // head of the queue drives the response port.
  assign r_valid_o = (count_q != 2'd0);
  assign r_data_o  = q_data_q[rd_ptr_q];
  assign r_opc_o   = q_opc_q[rd_ptr_q];
  assign r_id_o    = q_id_q[rd_ptr_q];

endmodule : hci_mem_bank

// ==== design/hci_static_subsys.sv ====
/*
 * static hci subsystem.
 * NB_CHAN initiator channels share one memory bank through the
 * static multiplexer, sel_i picks the channel that owns the port.
 */

`timescale 1ns/1ns

module hci_static_subsys
  import hci_mem_pkg::*;
  import hci_chan_pkg::*;
#(
  parameter int unsigned NB_CHAN   = 2,
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  chan_id_t                 sel_i,    // channel owning the bank.

  // channel requests.
  input  logic      [NB_CHAN-1:0]  req_i,
  input  mem_addr_t [NB_CHAN-1:0]  add_i,
  input  logic      [NB_CHAN-1:0]  wen_i,
  input  mem_data_t [NB_CHAN-1:0]  data_i,
  input  mem_be_t   [NB_CHAN-1:0]  be_i,
  input  logic      [NB_CHAN-1:0]  r_ready_i,

  // channel responses.
  output logic      [NB_CHAN-1:0]  gnt_o,
  output logic      [NB_CHAN-1:0]  r_valid_o,
  output mem_data_t [NB_CHAN-1:0]  r_data_o,
  output resp_opc_t [NB_CHAN-1:0]  r_opc_o
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mux to bank wires
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic       mem_req;
  mem_addr_t  mem_add;
  logic       mem_wen;
  mem_data_t  mem_data;
  mem_be_t    mem_be;
  chan_id_t   mem_id;
  logic       mem_gnt;    // bank back-pressure.
  logic       mem_r_valid;
  mem_data_t  mem_r_data;
  resp_opc_t  mem_r_opc;
  chan_id_t   mem_r_id;   // steers the response.
  logic       mem_r_ready;

  // channel select and response steering.
  hci_core_mux_static #(
    .NB_CHAN       ( NB_CHAN     )
  ) mux0 (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .sel_i         ( sel_i       ),
    .in_req_i      ( req_i       ),
    .in_add_i      ( add_i       ),
    .in_wen_i      ( wen_i       ),
    .in_data_i     ( data_i      ),
    .in_be_i       ( be_i        ),
    .in_r_ready_i  ( r_ready_i   ),
    .in_gnt_o      ( gnt_o       ),
    .in_r_valid_o  ( r_valid_o   ),
    .in_r_data_o   ( r_data_o    ),
    .in_r_opc_o    ( r_opc_o     ),
    .out_req_o     ( mem_req     ),
    .out_add_o     ( mem_add     ),
    .out_wen_o     ( mem_wen     ),
    .out_data_o    ( mem_data    ),
    .out_be_o      ( mem_be      ),
    .out_id_o      ( mem_id      ),
    .out_r_ready_o ( mem_r_ready ),
    .out_gnt_i     ( mem_gnt     ),
    .out_r_valid_i ( mem_r_valid ),
    .out_r_data_i  ( mem_r_data  ),
    .out_r_opc_i   ( mem_r_opc   ),
    .out_r_id_i    ( mem_r_id    )
  );

  // shared word memory.
  hci_mem_bank #(
    .MEM_WORDS ( MEM_WORDS   )
  ) bank0 (
    .clk_i     ( clk_i       ),
    .reset_i   ( reset_i     ),
    .req_i     ( mem_req     ),
    .add_i     ( mem_add     ),
    .wen_i     ( mem_wen     ),
    .data_i    ( mem_data    ),
    .be_i      ( mem_be      ),
    .id_i      ( mem_id      ),
    .gnt_o     ( mem_gnt     ),
    .r_valid_o ( mem_r_valid ),
    .r_data_o  ( mem_r_data  ),
    .r_opc_o   ( mem_r_opc   ),
    .r_id_o    ( mem_r_id    ),
    .r_ready_i ( mem_r_ready )
  );

endmodule : hci_static_subsys

// ==== tests/hci_static_subsys_assert.sv ====
/*
 * protocol checker for the static hci subsystem.
 * request hold, single response owner, response hold and grant
 * gating, bound onto every instance of the top level.
 */

`timescale 1ns/1ns

module hci_static_subsys_assert
  import hci_mem_pkg::*;
  import hci_chan_pkg::*;
#(
  parameter int unsigned NB_CHAN = 2
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  chan_id_t                 sel_i,
  input  logic      [NB_CHAN-1:0]  req_i,
  input  mem_addr_t [NB_CHAN-1:0]  add_i,
  input  logic      [NB_CHAN-1:0]  r_ready_i,
  input  logic      [NB_CHAN-1:0]  gnt_i,      // observed dut grant.
  input  logic      [NB_CHAN-1:0]  r_valid_i   // observed dut r_valid.
);

  a_one_valid : assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(r_valid_i)) else $error("more than one channel shows r_valid");

  for (genvar i = 0; i < NB_CHAN; i++) begin : g_chan
    // waiting initiator holds its address.
    a_add_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      req_i[i] && !gnt_i[i] |=> $stable(add_i[i])) else $error("address moved before grant");
    // response stays until taken.
    a_valid_hold : assert property (@(posedge clk_i) disable iff (reset_i)
      r_valid_i[i] && !r_ready_i[i] |=> r_valid_i[i]) else $error("r_valid dropped early");
    a_gnt_sel : assert property (@(posedge clk_i) disable iff (reset_i)
      gnt_i[i] |-> sel_i == chan_id_t'(i)) else $error("grant on unselected channel");
  end

endmodule : hci_static_subsys_assert

bind hci_static_subsys hci_static_subsys_assert #(
  .NB_CHAN   ( NB_CHAN   )
) assert0 (
  .clk_i     ( clk_i     ),
  .reset_i   ( reset_i   ),
  .sel_i     ( sel_i     ),
  .req_i     ( req_i     ),
  .add_i     ( add_i     ),
  .r_ready_i ( r_ready_i ),
  .gnt_i     ( gnt_o     ),
  .r_valid_i ( r_valid_o )
);

// ==== tests/tb_hci_static_subsys.sv ====
/*
 * testbench for the static hci subsystem.
 * random per-channel reads and writes, random select and r_ready,
 * checked against a byte-enable memory model and an in-order queue.
 */

`timescale 1ns/1ns

module tb_hci_static_subsys
  import hci_mem_pkg::*;
  import hci_chan_pkg::*;
();

  localparam int unsigned NB_CHAN     = 2;
  localparam int unsigned MEM_WORDS   = 256;
  localparam int          N_CYCLES    = 3000;  // random traffic length.
  localparam int          DRAIN_LIMIT = 200;   // cycles allowed to empty out.

  logic                     clk;
  logic                     reset;
  chan_id_t                 sel;
  logic      [NB_CHAN-1:0]  req;
  mem_addr_t [NB_CHAN-1:0]  add;
  logic      [NB_CHAN-1:0]  wen;
  mem_data_t [NB_CHAN-1:0]  data;
  mem_be_t   [NB_CHAN-1:0]  be;
  logic      [NB_CHAN-1:0]  r_ready;
  logic      [NB_CHAN-1:0]  gnt;
  logic      [NB_CHAN-1:0]  r_valid;
  mem_data_t [NB_CHAN-1:0]  r_data;
  resp_opc_t [NB_CHAN-1:0]  r_opc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // model state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  mem_data_t     model_mem [MEM_WORDS];
  mem_data_t     exp_data_q[$];   // expected responses, acceptance order.
  resp_opc_t     exp_opc_q[$];
  chan_id_t      exp_chan_q[$];
  logic [NB_CHAN-1:0] taken;      // request accepted at the last edge.
  integer        seed;
  int            bp_left;         // cycles of forced r_ready low.
  int            err_data, err_opc, err_chan, err_proto;
  int            n_acc, n_rsp;
  int            cyc;

  hci_static_subsys #(
    .NB_CHAN   ( NB_CHAN   ),
    .MEM_WORDS ( MEM_WORDS )
  ) dut0 (
    .clk_i     ( clk       ),
    .reset_i   ( reset     ),
    .sel_i     ( sel       ),
    .req_i     ( req       ),
    .add_i     ( add       ),
    .wen_i     ( wen       ),
    .data_i    ( data      ),
    .be_i      ( be        ),
    .r_ready_i ( r_ready   ),
    .gnt_o     ( gnt       ),
    .r_valid_o ( r_valid   ),
    .r_data_o  ( r_data    ),
    .r_opc_o   ( r_opc     )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_data(input string name, input mem_data_t got, input mem_data_t exp);
    if (got !== exp) begin
      err_data++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_opc(input string name, input resp_opc_t got, input resp_opc_t exp);
    if (got !== exp) begin
      err_opc++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_chan(input string name, input chan_id_t got, input chan_id_t exp);
    if (got !== exp) begin
      err_chan++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // look at the settled outputs mid-cycle, predict the coming edge.
  task automatic sample_cycle();
    int        n_valid;
    int        owner;
    int        idx;
    int        level;
    logic      popped;
    logic      exp_gnt;
    mem_data_t merged;
    n_valid = 0;
    owner   = 0;
    popped  = 1'b0;
    @(negedge clk);
    level = exp_chan_q.size();  // queue fill before this edge.
    for (int i = 0; i < NB_CHAN; i++) begin
      if (r_valid[i]) begin
        n_valid++;
        owner = i;
      end
    end
    if (n_valid > 1) begin
      err_proto++;
      $display("more than one channel shows r_valid at %0t", $time);
    end
    if (level == 0) begin
      if (n_valid != 0) begin
        err_proto++;
        $display("r_valid high with no request outstanding at %0t", $time);
      end
    end else if (n_valid == 0) begin
      err_proto++;
      $display("no r_valid although a response is pending at %0t", $time);
    end else begin
      check_chan("r_valid owner", chan_id_t'(owner), exp_chan_q[0]);
      if (r_ready[owner]) begin  // taken at the next edge.
        check_opc("r_opc", r_opc[owner], exp_opc_q[0]);
        check_data("r_data", r_data[owner], exp_data_q[0]);
        void'(exp_data_q.pop_front());
        void'(exp_opc_q.pop_front());
        void'(exp_chan_q.pop_front());
        n_rsp++;
        popped = 1'b1;
      end
    end
    exp_gnt = (level < 2) || popped;  // room once the head leaves.
    for (int i = 0; i < NB_CHAN; i++) begin
      if (sel == chan_id_t'(i)) begin
        if (gnt[i] !== exp_gnt) begin
          err_proto++;
          $display("Mismatch gnt[%0d]: got %h expected %h at %0t", i, gnt[i], exp_gnt, $time);
        end
      end else if (gnt[i] !== 1'b0) begin
        err_proto++;
        $display("gnt raised on unselected channel %0d at %0t", i, $time);
      end
      if (req[i] && gnt[i] && !taken[i]) begin
        idx = int'((add[i] >> 2) % MEM_WORDS);  // word index wraps.
        if (wen[i]) begin
          exp_data_q.push_back(model_mem[idx]);
          exp_opc_q.push_back(RESP_RD);
        end else begin
          merged = model_mem[idx];
          for (int b = 0; b < 4; b++) begin
            if (be[i][b]) merged[8*b +: 8] = data[i][8*b +: 8];
          end
          model_mem[idx] = merged;
          exp_data_q.push_back('0);
          exp_opc_q.push_back(RESP_WR_ACK);
        end
        exp_chan_q.push_back(chan_id_t'(i));
        n_acc++;
        taken[i] = 1'b1;
      end
    end
  endtask

  // new inputs just after the edge. drain stops new traffic.
  task automatic drive_cycle(input bit drain);
    @(posedge clk);
    #2;
    for (int i = 0; i < NB_CHAN; i++) begin
      if (taken[i] || !req[i]) begin
        taken[i] = 1'b0;
        if (!drain && rand_below(3) != 0) begin
          req[i]  = 1'b1;
          wen[i]  = rand_below(2) != 0;
          add[i]  = mem_addr_t'(rand_below(32) + 4 * MEM_WORDS * rand_below(4));
          data[i] = $random(seed);
          be[i]   = mem_be_t'(rand_below(16));
        end else begin
          req[i] = 1'b0;
        end
      end
    end
    if (drain) begin
      r_ready = '1;
      sel     = chan_id_t'((int'(sel) + 1) % NB_CHAN);  // visit every channel.
    end else begin
      if (bp_left > 0) bp_left--;
      else if (rand_below(40) == 0) bp_left = 8 + rand_below(24);  // long stall.
      for (int i = 0; i < NB_CHAN; i++) begin
        r_ready[i] = (bp_left > 0) ? 1'b0 : (rand_below(4) != 0);
      end
      if (rand_below(8) == 0) sel = chan_id_t'(rand_below(NB_CHAN));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    seed      = 32'h4a52735c;
    reset     = 1'b1;
    sel       = '0;
    req       = '0;
    add       = '0;
    wen       = '0;
    data      = '0;
    be        = '0;
    r_ready   = '0;
    taken     = '0;
    bp_left   = 0;
    err_data  = 0;
    err_opc   = 0;
    err_chan  = 0;
    err_proto = 0;
    n_acc     = 0;
    n_rsp     = 0;
    for (int w = 0; w < MEM_WORDS; w++) model_mem[w] = '0;

    repeat (2) @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    if (r_valid !== '0) begin
      err_proto++;
      $display("r_valid high right after reset");
    end
    if (gnt[0] !== 1'b1) begin
      err_proto++;
      $display("selected channel has no grant right after reset");
    end

    for (int n = 0; n < N_CYCLES; n++) begin
      drive_cycle(1'b0);
      sample_cycle();
    end

    // let pending requests and queued responses finish.
    cyc = 0;
    while (((req & ~taken) != '0 || exp_chan_q.size() != 0) && cyc < DRAIN_LIMIT) begin
      drive_cycle(1'b1);
      sample_cycle();
      cyc++;
    end
    if (cyc >= DRAIN_LIMIT) begin
      err_proto++;
      $display("timeout while waiting for outstanding requests and responses");
    end
    if (n_acc != n_rsp) begin
      err_proto++;
      $display("accepted %0d requests but received %0d responses", n_acc, n_rsp);
    end

    $display("error counts: data %0d, opcode %0d, channel %0d, protocol %0d (%0d requests)",
             err_data, err_opc, err_chan, err_proto, n_acc);
    if (err_data + err_opc + err_chan + err_proto == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_hci_static_subsys

// ==== vlog.f ====
design/hci_mem_pkg.sv
design/hci_chan_pkg.sv
design/hci_core_mux_static.sv
design/hci_mem_bank.sv
design/hci_static_subsys.sv
tests/hci_static_subsys_assert.sv
tests/tb_hci_static_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hci static subsystem testbench with verilator.
set -e

cd "$(dirname "$0")"

TOP=tb_hci_static_subsys
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module "$TOP" -o sim_tb

# the log decides pass or fail, so the run status is not used here.
./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -qx "Finished with no errors" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi
